// ==== src/soc_pkg.sv ====
package soc_pkg;

  // One bus request, held by the master until ack
  typedef struct packed {
    logic        req;
    logic        write;
    logic [15:0] addr;   // Word address
    logic [15:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;    // One-cycle pulse
    logic [15:0] rdata;  // Valid with ack
  } bus_rsp_t;

  // Command list word, also the TXDATA layout
  typedef struct packed {
    logic       last;    // End of list, never sent
    logic [5:0] spare;
    logic       dc;
    logic [7:0] data;
  } feed_entry_t;

  // Shield pins as mirrored on the board LEDs
  typedef struct packed {
    logic cs_n;
    logic sclk;
    logic mosi;
    logic dc;
  } lcd_pins_t;

  // Address map
  localparam logic [15:0] RAM_LO     = 16'h0000;
  localparam logic [15:0] RAM_HI     = 16'h0FFF;
  localparam logic [15:0] SPI_TXDATA = 16'h8000;
  localparam logic [15:0] SPI_STATUS = 16'h8001;
  localparam logic [15:0] SPI_CTRL   = 16'h8002;
  localparam logic [15:0] FEED_BASE  = 16'h0000;

  // STATUS bits
  localparam int ST_BUSY    = 0;
  localparam int ST_OVERRUN = 1;

  // CTRL fields
  localparam int CTRL_INV     = 0;
  localparam int CTRL_DIV_LSB = 4;
  localparam int CTRL_DIV_W   = 4;

endpackage

// ==== src/bus_ram.sv ====
`timescale 1ns/10ps

module bus_ram #(
  parameter logic [15:0] ADDR_LO = 16'h0000,
  parameter logic [15:0] ADDR_HI = 16'h0FFF
) (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::bus_req_t bus_req,
  output soc_pkg::bus_rsp_t bus_rsp
);

  localparam int DEPTH = int'(ADDR_HI) - int'(ADDR_LO) + 1;
  localparam int AW    = $clog2(DEPTH);

  logic [15:0] mem [DEPTH];
  logic [15:0] rdata_q;
  logic [15:0] offset;
  logic        in_win;
  logic        hit;
  logic        ack_q;

  assign in_win = (bus_req.addr >= ADDR_LO) && (bus_req.addr <= ADDR_HI);
  assign offset = bus_req.addr - ADDR_LO;
  assign hit    = bus_req.req && in_win && !ack_q;  // New access this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  // Storage and read data
  always_ff @(posedge clk) begin
    if (hit) begin
      if (bus_req.write) begin
        mem[offset[AW-1:0]] <= bus_req.wdata;
      end
      rdata_q <= mem[offset[AW-1:0]];  // Old word on a write
    end
  end

  assign bus_rsp = '{ack: ack_q, rdata: rdata_q};

  // Address is still held inside the window when the ack goes out
  a_ack_in_window: assert property (@(posedge clk) disable iff (rst)
    bus_rsp.ack |-> in_win)
    else $error("bus_ram acked an address outside its window");

endmodule

// ==== src/bus_interconnect.sv ====
`timescale 1ns/10ps

module bus_interconnect (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::bus_req_t feed_req,
  output soc_pkg::bus_rsp_t feed_rsp,
  input  logic              feed_busy,
  input  soc_pkg::bus_req_t host_req,
  output soc_pkg::bus_rsp_t host_rsp,
  output soc_pkg::bus_req_t ram_req,
  input  soc_pkg::bus_rsp_t ram_rsp,
  output soc_pkg::bus_req_t spi_req,
  input  soc_pkg::bus_rsp_t spi_rsp
);

  soc_pkg::bus_req_t m_req;
  soc_pkg::bus_rsp_t m_rsp;
  logic              sel_feed;
  logic              grant_q;
  logic              pend_q;     // Ack due this cycle, grant frozen
  logic              armed_q;
  logic [16:0]       key_q;      // write and addr of the last acked request
  logic              live;
  logic              ram_hit;
  logic              spi_hit;
  logic              unm_ack_q;

  assign sel_feed = pend_q ? grant_q : feed_busy;
  assign m_req    = sel_feed ? feed_req : host_req;

  // A request is forwarded until acked, then again only once it is new
  assign live = m_req.req &&
                (armed_q || (sel_feed != grant_q) || ({m_req.write, m_req.addr} != key_q));

  assign ram_hit = (m_req.addr >= soc_pkg::RAM_LO) && (m_req.addr <= soc_pkg::RAM_HI);
  assign spi_hit = (m_req.addr >= soc_pkg::SPI_TXDATA) && (m_req.addr <= soc_pkg::SPI_CTRL);

  always_comb begin
    ram_req       = m_req;
    ram_req.req   = live && ram_hit;
    spi_req       = m_req;
    spi_req.req   = live && spi_hit;
    m_rsp.ack     = ram_rsp.ack || spi_rsp.ack || unm_ack_q;
    m_rsp.rdata   = ram_rsp.ack ? ram_rsp.rdata : (spi_rsp.ack ? spi_rsp.rdata : 16'h0000);
  end

  assign feed_rsp = sel_feed ? m_rsp : '0;
  assign host_rsp = sel_feed ? '0 : m_rsp;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q   <= 1'b0;
      pend_q    <= 1'b0;
      armed_q   <= 1'b1;
      unm_ack_q <= 1'b0;
    end else begin
      grant_q   <= sel_feed;
      pend_q    <= live && !m_rsp.ack;
      unm_ack_q <= live && !ram_hit && !spi_hit && !unm_ack_q;  // Unmapped reads as 0
      if (m_rsp.ack) begin
        armed_q <= 1'b0;
      end else if (!m_req.req || (sel_feed != grant_q)) begin
        armed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (m_rsp.ack) begin
      key_q <= {m_req.write, m_req.addr};
    end
  end

  a_one_slave_ack: assert property (@(posedge clk) disable iff (rst)
    !(ram_rsp.ack && spi_rsp.ack))
    else $error("RAM and SPI acked in the same cycle");

endmodule

// ==== src/feed_engine.sv ====
`timescale 1ns/10ps

module feed_engine (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output soc_pkg::bus_req_t bus_req,
  input  soc_pkg::bus_rsp_t bus_rsp,
  output logic              busy,
  output logic              done
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    POLL,
    SEND,
    FINISH
  } state_t;

  state_t               state_q;
  logic                 start_q;
  logic                 gap_q;     // Req low for a cycle after each ack
  logic [15:0]          ptr_q;
  soc_pkg::feed_entry_t entry_q;
  soc_pkg::feed_entry_t rd_entry;

  assign rd_entry = soc_pkg::feed_entry_t'(bus_rsp.rdata);
  assign busy     = state_q inside {FETCH, POLL, SEND};
  assign done     = (state_q == FINISH);

  // Request follows the state
  always_comb begin
    bus_req     = '0;
    bus_req.req = busy && !gap_q;
    case (state_q)
      FETCH: bus_req.addr = ptr_q;
      POLL:  bus_req.addr = soc_pkg::SPI_STATUS;
      SEND: begin
        bus_req.write = 1'b1;
        bus_req.addr  = soc_pkg::SPI_TXDATA;
        bus_req.wdata = entry_q;
      end
      default: bus_req.addr = 16'h0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      start_q <= 1'b0;
      gap_q   <= 1'b0;
      ptr_q   <= soc_pkg::FEED_BASE;
    end else begin
      start_q <= start;
      gap_q   <= bus_rsp.ack;
      case (state_q)
        IDLE: begin
          if (start && !start_q) begin  // Rising edge only
            ptr_q   <= soc_pkg::FEED_BASE;
            state_q <= FETCH;
          end
        end
        FETCH: begin
          if (bus_rsp.ack) begin
            state_q <= rd_entry.last ? FINISH : POLL;
          end
        end
        POLL: begin
          // Spin until the shifter is free
          if (bus_rsp.ack && !bus_rsp.rdata[soc_pkg::ST_BUSY]) begin
            state_q <= SEND;
          end
        end
        SEND: begin
          if (bus_rsp.ack) begin
            ptr_q   <= ptr_q + 16'd1;
            state_q <= FETCH;
          end
        end
        FINISH:  state_q <= IDLE;  // One-cycle done
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == FETCH) && bus_rsp.ack) begin
      entry_q <= rd_entry;
    end
  end

endmodule

// ==== src/lcd_spi_regs.sv ====
`timescale 1ns/10ps

module lcd_spi_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  soc_pkg::bus_req_t    bus_req,
  output soc_pkg::bus_rsp_t    bus_rsp,
  input  logic                 shift_busy,
  output logic                 load,
  output soc_pkg::feed_entry_t entry,
  output logic [3:0]           div,
  output logic                 inv
);

  logic                 ack_q;
  logic                 acc;
  logic                 tx_wr;
  logic                 st_rd;
  logic                 ctrl_wr;
  logic                 load_q;
  logic                 overrun_q;
  logic                 inv_q;
  logic [3:0]           div_q;
  logic [15:0]          rdata_q;
  logic [15:0]          status_word;
  logic [15:0]          ctrl_word;
  soc_pkg::feed_entry_t entry_q;

  assign acc     = bus_req.req && !ack_q;
  assign tx_wr   = acc && bus_req.write && (bus_req.addr == soc_pkg::SPI_TXDATA);
  assign st_rd   = acc && !bus_req.write && (bus_req.addr == soc_pkg::SPI_STATUS);
  assign ctrl_wr = acc && bus_req.write && (bus_req.addr == soc_pkg::SPI_CTRL);

  always_comb begin
    status_word                       = 16'h0000;
    status_word[soc_pkg::ST_BUSY]     = shift_busy;
    status_word[soc_pkg::ST_OVERRUN]  = overrun_q;
    ctrl_word                         = 16'h0000;
    ctrl_word[soc_pkg::CTRL_INV]      = inv_q;
    ctrl_word[soc_pkg::CTRL_DIV_LSB +: soc_pkg::CTRL_DIV_W] = div_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q     <= 1'b0;
      load_q    <= 1'b0;
      overrun_q <= 1'b0;
      inv_q     <= 1'b0;
      div_q     <= 4'd0;
    end else begin
      ack_q  <= acc;
      load_q <= tx_wr && !shift_busy;  // Strobe lands in the ack cycle
      if (tx_wr && shift_busy) begin
        overrun_q <= 1'b1;  // Byte dropped
      end else if (st_rd) begin
        overrun_q <= 1'b0;  // Clear on read
      end
      if (ctrl_wr) begin
        inv_q <= bus_req.wdata[soc_pkg::CTRL_INV];
        div_q <= bus_req.wdata[soc_pkg::CTRL_DIV_LSB +: soc_pkg::CTRL_DIV_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_wr) begin
      entry_q <= soc_pkg::feed_entry_t'(bus_req.wdata);
    end
    if (acc) begin
      case (bus_req.addr)
        soc_pkg::SPI_STATUS: rdata_q <= status_word;
        soc_pkg::SPI_CTRL:   rdata_q <= ctrl_word;
        default:             rdata_q <= 16'h0000;  // TXDATA is write only
      endcase
    end
  end

  assign bus_rsp = '{ack: ack_q, rdata: rdata_q};
  assign load    = load_q;
  assign entry   = entry_q;
  assign div     = div_q;
  assign inv     = inv_q;

endmodule

// ==== src/lcd_spi_shifter.sv ====
`timescale 1ns/10ps

module lcd_spi_shifter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  soc_pkg::feed_entry_t entry,
  input  logic [3:0]           div,
  output logic                 busy,
  output soc_pkg::lcd_pins_t   pins
);

  logic       busy_q;
  logic       cs_n_q;
  logic       sclk_q;
  logic       dc_q;
  logic [7:0] shreg_q;
  logic [3:0] div_q;    // Held for the whole byte
  logic [3:0] cnt_q;
  logic [2:0] bit_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      cs_n_q  <= 1'b1;
      sclk_q  <= 1'b0;
      dc_q    <= 1'b0;
      shreg_q <= 8'h00;
      div_q   <= 4'd0;
      cnt_q   <= 4'd0;
      bit_q   <= 3'd0;
    end else if (load && !busy_q) begin
      busy_q  <= 1'b1;
      cs_n_q  <= 1'b0;
      sclk_q  <= 1'b0;
      dc_q    <= entry.dc;
      shreg_q <= entry.data;  // MSB out first
      div_q   <= div;
      cnt_q   <= 4'd0;
      bit_q   <= 3'd0;
    end else if (busy_q) begin
      if (cnt_q == div_q) begin
        cnt_q <= 4'd0;
        if (!sclk_q) begin
          sclk_q <= 1'b1;  // Slave samples here
        end else begin
          sclk_q  <= 1'b0;
          shreg_q <= {shreg_q[6:0], 1'b0};  // Next bit while low
          if (bit_q == 3'd7) begin
            busy_q <= 1'b0;
            cs_n_q <= 1'b1;
          end else begin
            bit_q <= bit_q + 3'd1;
          end
        end
      end else begin
        cnt_q <= cnt_q + 4'd1;
      end
    end
  end

  // Eight shifts leave the register empty, so mosi idles low
  assign busy = busy_q;
  assign pins = '{cs_n: cs_n_q, sclk: sclk_q, mosi: shreg_q[7], dc: dc_q};

  a_sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
    pins.cs_n |-> !pins.sclk)
    else $error("sclk high while cs_n deasserted");

  a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
    load |-> !busy_q)
    else $error("load strobe arrived while shifter busy");

endmodule

// ==== src/de10nano_core.sv ====
`timescale 1ns/10ps

module de10nano_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  soc_pkg::bus_req_t  host_req,
  output soc_pkg::bus_rsp_t  host_rsp,
  output soc_pkg::lcd_pins_t lcd,
  output logic               led_inv,
  output logic               feed_busy,
  output logic               feed_done
);

  soc_pkg::bus_req_t    feed_req;
  soc_pkg::bus_rsp_t    feed_rsp;
  soc_pkg::bus_req_t    ram_req;
  soc_pkg::bus_rsp_t    ram_rsp;
  soc_pkg::bus_req_t    spi_req;
  soc_pkg::bus_rsp_t    spi_rsp;
  logic                 shift_load;
  logic                 shift_busy;
  soc_pkg::feed_entry_t shift_entry;
  logic [3:0]           shift_div;

  // Bus master in place of the CPU
  feed_engine i_feed (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .bus_req (feed_req),
    .bus_rsp (feed_rsp),
    .busy    (feed_busy),
    .done    (feed_done)
  );

  bus_interconnect i_ic (
    .clk       (clk),
    .rst       (rst),
    .feed_req  (feed_req),
    .feed_rsp  (feed_rsp),
    .feed_busy (feed_busy),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .ram_req   (ram_req),
    .ram_rsp   (ram_rsp),
    .spi_req   (spi_req),
    .spi_rsp   (spi_rsp)
  );

  bus_ram #(.ADDR_LO(soc_pkg::RAM_LO), .ADDR_HI(soc_pkg::RAM_HI)) i_ram (
    .clk     (clk),
    .rst     (rst),
    .bus_req (ram_req),
    .bus_rsp (ram_rsp)
  );

  // Shield registers and the shifter they steer
  lcd_spi_regs i_regs (
    .clk        (clk),
    .rst        (rst),
    .bus_req    (spi_req),
    .bus_rsp    (spi_rsp),
    .shift_busy (shift_busy),
    .load       (shift_load),
    .entry      (shift_entry),
    .div        (shift_div),
    .inv        (led_inv)
  );

  lcd_spi_shifter i_shift (
    .clk   (clk),
    .rst   (rst),
    .load  (shift_load),
    .entry (shift_entry),
    .div   (shift_div),
    .busy  (shift_busy),
    .pins  (lcd)
  );

endmodule

// ==== tb/tb_de10nano_core.sv ====
`timescale 1ns/10ps

module tb_de10nano_core;

  localparam int FEED_LEN     = 12;
  localparam int BUS_WAIT_MAX = 20000;    // Host may stall behind a whole feed run
  localparam int POLL_MAX     = 200;
  // Feed of FEED_LEN+1 entries at div 15 is about 13 x 300 cycles, some 16 us
  localparam int WATCHDOG_NS  = 200_000;

  logic               clk;
  logic               rst;
  logic               start;
  soc_pkg::bus_req_t  host_req;
  soc_pkg::bus_rsp_t  host_rsp;
  soc_pkg::lcd_pins_t lcd;
  logic               led_inv;
  logic               feed_busy;
  logic               feed_done;

  integer     seed = 64;
  int         errors = 0;
  logic       busy_at_ack;        // feed_busy seen with the last host ack
  logic [8:0] cap_q [$];          // {dc, byte} per finished SPI transfer
  logic [7:0] shift_byte = 8'h00;
  int         bit_cnt = 0;
  logic       sclk_prev = 1'b0;
  logic       cs_prev = 1'b1;
  int         cs_fall_cnt = 0;
  int         done_cnt = 0;

  de10nano_core i_dut (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .lcd       (lcd),
    .led_inv   (led_inv),
    .feed_busy (feed_busy),
    .feed_done (feed_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // SPI mode 0 monitor, bit taken on each sclk rise
  always @(negedge clk) begin
    if (rst || lcd.cs_n) begin
      bit_cnt = 0;
    end else if (lcd.sclk && !sclk_prev) begin
      shift_byte = {shift_byte[6:0], lcd.mosi};  // MSB first
      bit_cnt++;
      if (bit_cnt == 8) begin
        cap_q.push_back({lcd.dc, shift_byte});
        bit_cnt = 0;
      end
    end
    if (cs_prev && !lcd.cs_n) begin
      cs_fall_cnt++;
    end
    if (feed_done) begin
      done_cnt++;
    end
    sclk_prev = lcd.sclk;
    cs_prev   = lcd.cs_n;
  end

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  // Request held until ack, dropped in the cycle after
  task automatic bus_access(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
    int waited;
    @(posedge clk);
    #1;
    host_req = '{req: 1'b1, write: write, addr: addr, wdata: wdata};
    waited = 0;
    while (!host_rsp.ack && waited < BUS_WAIT_MAX) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!host_rsp.ack) begin
      report_failure($sformatf("no bus ack for address %h", addr));
    end
    rdata       = host_rsp.rdata;
    busy_at_ack = feed_busy;
    @(posedge clk);
    #1;
    host_req = '0;
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    bus_access(1'b0, addr, 16'h0000, data);
  endtask

  task automatic wait_spi_idle(input string name);
    logic [15:0] status;
    int          polls;
    status = 16'h0001;
    polls  = 0;
    while (status[soc_pkg::ST_BUSY] && polls < POLL_MAX) begin
      bus_read(soc_pkg::SPI_STATUS, status);
      polls++;
    end
    if (status[soc_pkg::ST_BUSY]) begin
      report_failure($sformatf("%s: shifter still busy after %0d polls", name, POLL_MAX));
    end
  endtask

  // Rising edge on start, held until the engine claims the bus
  task automatic start_feed(input string name);
    int waited;
    @(posedge clk);
    #1;
    start  = 1'b1;
    waited = 0;
    while (!feed_busy && waited < 20) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!feed_busy) begin
      report_failure($sformatf("%s: feed_busy never rose after start", name));
    end
    start = 1'b0;
  endtask

  task automatic reset_state;
    if (lcd.cs_n !== 1'b1) report_mismatch("reset_state cs_n", 16'h1, 16'(lcd.cs_n));
    if (lcd.sclk !== 1'b0) report_mismatch("reset_state sclk", 16'h0, 16'(lcd.sclk));
    if (lcd.mosi !== 1'b0) report_mismatch("reset_state mosi", 16'h0, 16'(lcd.mosi));
    if (led_inv !== 1'b0) report_mismatch("reset_state led_inv", 16'h0, 16'(led_inv));
    if (feed_busy !== 1'b0) report_mismatch("reset_state feed_busy", 16'h0, 16'(feed_busy));
    if (feed_done !== 1'b0) report_mismatch("reset_state feed_done", 16'h0, 16'(feed_done));
    if (host_rsp.ack !== 1'b0) report_mismatch("reset_state ack", 16'h0, 16'(host_rsp.ack));
  endtask

  task automatic ram_access;
    logic [15:0] addrs [16];
    logic [15:0] words [16];
    logic [15:0] rdata;
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
      rnd      = $random(seed);
      addrs[i] = {4'h0, i[3:0], rnd[7:0]};  // One word per 256-word slice
      words[i] = rnd[31:16];
      bus_write(addrs[i], words[i]);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(addrs[i], rdata);
      if (rdata !== words[i]) begin
        report_mismatch($sformatf("ram_access @%h", addrs[i]), words[i], rdata);
      end
    end
    bus_read(16'h4000, rdata);  // Unmapped space
    if (rdata !== 16'h0000) report_mismatch("ram_access unmapped", 16'h0000, rdata);
  endtask

  task automatic direct_byte;
    logic [15:0] rdata;
    logic [31:0] rnd;
    logic [7:0]  data;
    logic [8:0]  got;
    rnd  = $random(seed);
    data = rnd[7:0];
    bus_write(soc_pkg::SPI_CTRL, 16'h0021);  // div 2 in bits 7:4, invert on
    if (led_inv !== 1'b1) report_mismatch("direct_byte led_inv", 16'h1, 16'(led_inv));
    bus_read(soc_pkg::SPI_CTRL, rdata);
    if (rdata !== 16'h0021) report_mismatch("direct_byte CTRL", 16'h0021, rdata);
    cap_q.delete();
    bus_write(soc_pkg::SPI_TXDATA, {7'h00, 1'b1, data});
    bus_read(soc_pkg::SPI_STATUS, rdata);
    if (rdata[soc_pkg::ST_BUSY] !== 1'b1) begin
      report_mismatch("direct_byte STATUS busy", 16'h1, 16'(rdata[soc_pkg::ST_BUSY]));
    end
    wait_spi_idle("direct_byte");
    if (cap_q.size() != 1) begin
      report_mismatch("direct_byte byte count", 16'h1, 16'(cap_q.size()));
    end else begin
      got = cap_q.pop_front();
      if (got !== {1'b1, data}) report_mismatch("direct_byte byte", 16'({1'b1, data}), 16'(got));
    end
  endtask

  task automatic overrun;
    logic [15:0] rdata;
    logic [31:0] rnd;
    logic [8:0]  got;
    rnd = $random(seed);
    cap_q.delete();
    bus_write(soc_pkg::SPI_TXDATA, {8'h00, rnd[7:0]});
    bus_write(soc_pkg::SPI_TXDATA, {7'h00, 1'b1, rnd[15:8]});  // Lands while busy
    bus_read(soc_pkg::SPI_STATUS, rdata);
    if (rdata[soc_pkg::ST_OVERRUN] !== 1'b1) begin
      report_mismatch("overrun first STATUS", 16'h1, 16'(rdata[soc_pkg::ST_OVERRUN]));
    end
    bus_read(soc_pkg::SPI_STATUS, rdata);
    if (rdata[soc_pkg::ST_OVERRUN] !== 1'b0) begin
      report_mismatch("overrun second STATUS", 16'h0, 16'(rdata[soc_pkg::ST_OVERRUN]));
    end
    wait_spi_idle("overrun");
    if (cap_q.size() != 1) begin
      report_mismatch("overrun byte count", 16'h1, 16'(cap_q.size()));
    end else begin
      got = cap_q.pop_front();
      if (got !== {1'b0, rnd[7:0]}) report_mismatch("overrun byte", 16'(rnd[7:0]), 16'(got));
    end
  endtask

  task automatic feed_run;
    logic [15:0] list [FEED_LEN];
    logic [15:0] rdata;
    logic [31:0] rnd;
    logic [8:0]  got;
    logic [8:0]  exp;
    int          done_before;
    bus_write(soc_pkg::SPI_CTRL, 16'h0010);  // div 1, invert off
    for (int i = 0; i < FEED_LEN; i++) begin
      rnd     = $random(seed);
      list[i] = {1'b0, rnd[14:0]};  // Spare bits random as well
      bus_write(soc_pkg::FEED_BASE + 16'(i), list[i]);
    end
    rnd = $random(seed);
    bus_write(soc_pkg::FEED_BASE + 16'(FEED_LEN), {1'b1, rnd[14:0]});
    cap_q.delete();
    done_before = done_cnt;
    start_feed("feed_run");
    bus_read(soc_pkg::FEED_BASE, rdata);  // Issued while the engine owns the bus
    if (busy_at_ack !== 1'b0) begin
      report_failure("feed_run: host read was acked while feed_busy was high");
    end
    if (done_cnt != done_before + 1) begin
      report_mismatch("feed_run done pulses", 16'(done_before + 1), 16'(done_cnt));
    end
    if (rdata !== list[0]) report_mismatch("feed_run host read", list[0], rdata);
    wait_spi_idle("feed_run");  // Last byte still shifts after done
    if (cap_q.size() != FEED_LEN) begin
      report_mismatch("feed_run byte count", 16'(FEED_LEN), 16'(cap_q.size()));
    end
    for (int i = 0; i < FEED_LEN && cap_q.size() > 0; i++) begin
      got = cap_q.pop_front();
      exp = {list[i][8], list[i][7:0]};
      if (got !== exp) report_mismatch($sformatf("feed_run entry %0d", i), 16'(exp), 16'(got));
    end
  endtask

  task automatic empty_feed;
    int done_before;
    int cs_before;
    int waited;
    bus_write(soc_pkg::FEED_BASE, 16'h8000);  // List ends at once
    cap_q.delete();
    done_before = done_cnt;
    cs_before   = cs_fall_cnt;
    start_feed("empty_feed");
    waited = 0;
    while (done_cnt == done_before && waited < POLL_MAX) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (done_cnt != done_before + 1) begin
      report_mismatch("empty_feed done pulses", 16'(done_before + 1), 16'(done_cnt));
    end
    if (feed_busy !== 1'b0) report_mismatch("empty_feed feed_busy", 16'h0, 16'(feed_busy));
    if (cs_fall_cnt != cs_before) begin
      report_failure("empty_feed: cs_n fell although the list was empty");
    end
    if (cap_q.size() != 0) report_mismatch("empty_feed byte count", 16'h0, 16'(cap_q.size()));
  endtask

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    host_req = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state();
    ram_access();
    direct_byte();
    overrun();
    feed_run();
    empty_feed();
    $display("Run complete with %0d error(s)", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== project.f ====
src/soc_pkg.sv
src/bus_ram.sv
src/bus_interconnect.sv
src/feed_engine.sv
src/lcd_spi_regs.sv
src/lcd_spi_shifter.sv
src/de10nano_core.sv
tb/tb_de10nano_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_de10nano_core
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Mdir "$OBJ" --top-module "$TOP" -o "$TOP" -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
